// ==== cache_array.sv ====
//--------------------
// Direct-mapped cache array
// Tag, valid, dirty and data storage for all lines
// Compare mode for lookups, access mode for fills
// and write-back reads
//--------------------
`timescale 1ns/1ns
`default_nettype none
`include "mem_sys_defs.svh"

module cache_array (
   input  logic                     clk,
   input  logic                     rst,
   input  cache_pkg::cache_cmd_t    cmd,
   output cache_pkg::cache_status_t status
);
   import cache_pkg::*;

   localparam int LINES      = `MEM_SYS_LINES;
   localparam int WORDS      = `MEM_SYS_WORDS_PER_LINE;
   localparam int WORD_SEL_W = $clog2(WORDS);

   logic [`MEM_SYS_DATA_W-1:0] data_mem [LINES][WORDS];
   tag_t                       tag_mem [LINES];
   logic [LINES-1:0]           valid_q;
   logic [LINES-1:0]           dirty_q;

   logic [WORD_SEL_W-1:0] word_sel;
   tag_t                  stored_tag;
   logic                  line_hit;
   logic                  wr_comp;
   logic                  wr_fill;

   // Offset bit 0 is the byte within the word
   assign word_sel   = cmd.offset[`MEM_SYS_OFFSET_W-1 -: WORD_SEL_W];
   assign stored_tag = tag_mem[cmd.index];
   assign line_hit   = valid_q[cmd.index] & (stored_tag == cmd.tag);

   // Compare writes only land on a valid matching line
   assign wr_comp = cmd.en & cmd.write & cmd.comp & line_hit;
   assign wr_fill = cmd.en & cmd.write & ~cmd.comp;

   always_comb begin
      status.hit     = line_hit;
      status.valid   = valid_q[cmd.index];
      status.dirty   = dirty_q[cmd.index];
      status.tag_out = stored_tag;
      status.rdata   = data_mem[cmd.index][word_sel];
   end

   // Data and tag storage
   always_ff @(posedge clk) begin
      if (wr_comp | wr_fill) begin
         data_mem[cmd.index][word_sel] <= cmd.wdata;
      end
      if (wr_fill) begin
         tag_mem[cmd.index] <= cmd.tag;
      end
   end

   // Line state, a fill leaves the line clean
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_fill) begin
         valid_q[cmd.index] <= 1'b1;
         dirty_q[cmd.index] <= 1'b0;
      end else if (wr_comp) begin
         dirty_q[cmd.index] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
//--------------------
// Cache controller
// FSM that runs the compare, the optional write-back,
// the refill and the final compare for each request
//--------------------
`timescale 1ns/1ns
`default_nettype none
`include "mem_sys_defs.svh"

module cache_ctrl (
   input  logic                       clk,
   input  logic                       rst,
   input  cpu_if_pkg::cpu_req_t       req,
   output cpu_if_pkg::cpu_rsp_t       rsp,
   output logic                       busy,
   output logic                       err,
   output cache_pkg::cache_cmd_t      cache_cmd,
   input  cache_pkg::cache_status_t   cache_status,
   output cache_pkg::mem_cmd_t        mem_cmd,
   input  logic [`MEM_SYS_DATA_W-1:0] mem_rdata,
   input  logic                       mem_err
);
   import cpu_if_pkg::*;
   import cache_pkg::*;

   localparam int WORDS       = `MEM_SYS_WORDS_PER_LINE;
   localparam int RD_LAT      = `MEM_SYS_RD_LAT;
   localparam int REFILL_LAST = WORDS + RD_LAT - 1;

   typedef enum logic [2:0] {
      S_IDLE,
      S_COMP,
      S_WB,
      S_REFILL,
      S_FINAL,
      S_DONE
   } state_t;

   state_t      state_q;
   state_t      state_d;
   logic [2:0]  cnt_q;
   logic [2:0]  cnt_d;
   logic [2:0]  fill_cnt;
   cpu_req_t    req_q;
   cache_addr_t req_a;

   logic new_req;
   logic idle_like;
   logic accept;
   logic drop;
   logic load_rsp;
   logic hit_d;
   logic hit_q;
   logic err_q;
   logic [`MEM_SYS_DATA_W-1:0] rdata_q;

   assign req_a    = req_q.addr;
   // Word being written into the line during refill
   assign fill_cnt = cnt_q - 3'(RD_LAT);

   // New requests only in IDLE or in the done cycle
   assign new_req   = req.rd | req.wr;
   assign idle_like = (state_q == S_IDLE) || (state_q == S_DONE);
   assign accept    = new_req & idle_like & ~req.addr[0];
   assign drop      = new_req & ~accept;

   assign busy = ~idle_like;
   assign err  = err_q;
   assign rsp  = '{done: (state_q == S_DONE), hit: hit_q, rdata: rdata_q};

   always_comb begin
      state_d  = state_q;
      cnt_d    = cnt_q;
      load_rsp = 1'b0;
      hit_d    = 1'b0;

      cache_cmd        = '0;
      cache_cmd.tag    = req_a.tag;
      cache_cmd.index  = req_a.index;
      cache_cmd.offset = req_a.offset;
      cache_cmd.wdata  = req_q.wdata;

      mem_cmd       = '0;
      mem_cmd.addr  = {req_a.tag, req_a.index, cnt_q[1:0], 1'b0};
      mem_cmd.wdata = cache_status.rdata;

      case (state_q)
         S_IDLE, S_DONE: begin
            state_d = accept ? S_COMP : S_IDLE;
         end

         // Lookup, the cache performs a write on a hit by itself
         S_COMP: begin
            cache_cmd.en    = 1'b1;
            cache_cmd.comp  = 1'b1;
            cache_cmd.write = req_q.wr;
            cnt_d           = '0;
            if (cache_status.hit) begin
               load_rsp = 1'b1;
               hit_d    = 1'b1;
               state_d  = S_DONE;
            end else if (cache_status.valid && cache_status.dirty) begin
               state_d = S_WB;
            end else begin
               state_d = S_REFILL;
            end
         end

         // Old line goes back to the address of its stored tag
         S_WB: begin
            cache_cmd.en     = 1'b1;
            cache_cmd.offset = {cnt_q[1:0], 1'b0};
            mem_cmd.wr       = 1'b1;
            mem_cmd.addr     = {cache_status.tag_out, req_a.index, cnt_q[1:0], 1'b0};
            if (cnt_q == 3'(WORDS - 1)) begin
               cnt_d   = '0;
               state_d = S_REFILL;
            end else begin
               cnt_d = cnt_q + 1'b1;
            end
         end

         // Reads issue first, fills trail them by the read latency
         S_REFILL: begin
            if (cnt_q < 3'(WORDS)) begin
               mem_cmd.rd = 1'b1;
            end
            if (cnt_q >= 3'(RD_LAT)) begin
               cache_cmd.en     = 1'b1;
               cache_cmd.write  = 1'b1;
               cache_cmd.offset = {fill_cnt[1:0], 1'b0};
               cache_cmd.wdata  = mem_rdata;
            end
            cnt_d = cnt_q + 1'b1;
            if (cnt_q == 3'(REFILL_LAST)) begin
               state_d = S_FINAL;
            end
         end

         // Repeat the original access on the refilled line
         S_FINAL: begin
            cache_cmd.en    = 1'b1;
            cache_cmd.comp  = 1'b1;
            cache_cmd.write = req_q.wr;
            load_rsp        = 1'b1;
            state_d         = S_DONE;
         end

         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= S_IDLE;
         cnt_q   <= '0;
         err_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         // Sticky until reset
         err_q   <= err_q | drop | mem_err;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= req;
      end
      if (load_rsp) begin
         hit_q   <= hit_d;
         rdata_q <= cache_status.rdata;
      end
   end

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
//--------------------
// Cache and memory types
// Address fields, cache command and status,
// and the main memory command
//--------------------
`default_nettype none
`include "mem_sys_defs.svh"

package cache_pkg;

   typedef logic [`MEM_SYS_TAG_W-1:0]    tag_t;
   typedef logic [`MEM_SYS_INDEX_W-1:0]  index_t;
   typedef logic [`MEM_SYS_OFFSET_W-1:0] offset_t;

   // Byte address viewed as cache fields
   typedef struct packed {
      tag_t    tag;
      index_t  index;
      offset_t offset;
   } cache_addr_t;

   // Main memory command, addr is a word aligned byte address
   typedef struct packed {
      logic                       rd;
      logic                       wr;
      logic [`MEM_SYS_ADDR_W-1:0] addr;
      logic [`MEM_SYS_DATA_W-1:0] wdata;
   } mem_cmd_t;

   typedef struct packed {
      logic                       en;
      logic                       comp;
      logic                       write;
      tag_t                       tag;
      index_t                     index;
      offset_t                    offset;
      logic [`MEM_SYS_DATA_W-1:0] wdata;
   } cache_cmd_t;

   // Line metadata and selected word of the addressed line
   typedef struct packed {
      logic                       hit;
      logic                       valid;
      logic                       dirty;
      tag_t                       tag_out;
      logic [`MEM_SYS_DATA_W-1:0] rdata;
   } cache_status_t;

endpackage

`default_nettype wire

// ==== cpu_if_pkg.sv ====
//--------------------
// Processor interface types
// Request and response carried between the
// processor and the memory system
//--------------------
`default_nettype none
`include "mem_sys_defs.svh"

package cpu_if_pkg;

   // One-cycle strobe request, word aligned byte address
   typedef struct packed {
      logic                       rd;
      logic                       wr;
      logic [`MEM_SYS_ADDR_W-1:0] addr;
      logic [`MEM_SYS_DATA_W-1:0] wdata;
   } cpu_req_t;

   // Completion, rdata valid together with done
   typedef struct packed {
      logic                       done;
      logic                       hit;
      logic [`MEM_SYS_DATA_W-1:0] rdata;
   } cpu_rsp_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+.
cpu_if_pkg.sv
cache_pkg.sv
cache_array.sv
four_bank_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_checker.sv
tb_mem_system.sv

// ==== four_bank_mem.sv ====
//--------------------
// Four-bank interleaved memory
// Banks selected by address bits 2 and 1, fixed read
// latency, per-bank busy tracking and conflict error
//--------------------
`timescale 1ns/1ns
`default_nettype none
`include "mem_sys_defs.svh"

module four_bank_mem (
   input  logic                       clk,
   input  logic                       rst,
   input  cache_pkg::mem_cmd_t        cmd,
   output logic [`MEM_SYS_DATA_W-1:0] rdata,
   output logic                       err
);
   localparam int BANKS      = 4;
   localparam int ROW_W      = `MEM_SYS_ADDR_W - 3;
   localparam int BANK_WORDS = 2 ** ROW_W;
   localparam int RD_LAT     = `MEM_SYS_RD_LAT;
   localparam int BUSY       = `MEM_SYS_BANK_BUSY;
   localparam int BUSY_W     = $clog2(BUSY);

   // Whole 64 KiB space starts cleared
   logic [`MEM_SYS_DATA_W-1:0] bank_mem [BANKS][BANK_WORDS] = '{default: '0};
   logic [`MEM_SYS_DATA_W-1:0] rd_pipe [RD_LAT];
   logic [BUSY_W-1:0]          busy_cnt [BANKS];

   logic [1:0]       bank;
   logic [ROW_W-1:0] row;
   logic             access;
   logic             conflict;

   assign bank   = cmd.addr[2:1];
   assign row    = cmd.addr[`MEM_SYS_ADDR_W-1:3];
   assign access = cmd.rd | cmd.wr;

   // Both strobes at once, or a hit on a bank still recovering
   assign conflict = (cmd.rd & cmd.wr) | (access & (busy_cnt[bank] != '0));

   assign rdata = rd_pipe[RD_LAT-1];

   always_ff @(posedge clk) begin
      if (cmd.wr) begin
         bank_mem[bank][row] <= cmd.wdata;
      end
      if (cmd.rd) begin
         rd_pipe[0] <= bank_mem[bank][row];
      end
      // Later stages keep the older read in flight
      for (int i = 1; i < RD_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // Counter reloads on access, bank is free again once it is zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < BANKS; b++) begin
            if (access && (bank == 2'(b))) begin
               busy_cnt[b] <= BUSY_W'(BUSY - 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else begin
         err <= conflict;
      end
   end

endmodule

`default_nettype wire

// ==== mem_sys_defs.svh ====
//--------------------
// Memory system parameters
// Address and data widths, cache geometry and
// main memory timing shared by packages and RTL
//--------------------
`ifndef MEM_SYS_DEFS_SVH
`define MEM_SYS_DEFS_SVH

// Processor side widths
`define MEM_SYS_ADDR_W 16
`define MEM_SYS_DATA_W 16

// Address split, tag + index + offset
`define MEM_SYS_TAG_W 5
`define MEM_SYS_INDEX_W 8
`define MEM_SYS_OFFSET_W 3

// Cache geometry
`define MEM_SYS_LINES 256
`define MEM_SYS_WORDS_PER_LINE 4

// Main memory timing in cycles
`define MEM_SYS_RD_LAT 2
`define MEM_SYS_BANK_BUSY 4

`endif

// ==== mem_system.sv ====
//--------------------
// Memory system top
// Cache controller, direct-mapped cache array and
// four-bank main memory
//--------------------
`timescale 1ns/1ns
`default_nettype none
`include "mem_sys_defs.svh"

module mem_system (
   input  logic                 clk,
   input  logic                 rst,
   input  cpu_if_pkg::cpu_req_t req,
   output cpu_if_pkg::cpu_rsp_t rsp,
   output logic                 busy,
   output logic                 err
);
   import cache_pkg::*;

   cache_cmd_t                 cache_cmd;
   cache_status_t              cache_status;
   mem_cmd_t                   mem_cmd;
   logic [`MEM_SYS_DATA_W-1:0] mem_rdata;
   logic                       mem_err;

   cache_ctrl i_ctrl (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .rsp          (rsp),
      .busy         (busy),
      .err          (err),
      .cache_cmd    (cache_cmd),
      .cache_status (cache_status),
      .mem_cmd      (mem_cmd),
      .mem_rdata    (mem_rdata),
      .mem_err      (mem_err)
   );

   cache_array i_cache (
      .clk    (clk),
      .rst    (rst),
      .cmd    (cache_cmd),
      .status (cache_status)
   );

   four_bank_mem i_mem (
      .clk   (clk),
      .rst   (rst),
      .cmd   (mem_cmd),
      .rdata (mem_rdata),
      .err   (mem_err)
   );

endmodule

`default_nettype wire

// ==== mem_system_checker.sv ====
//--------------------
// Memory system protocol checker
// Concurrent assertions on the top-level request,
// response, busy and err signals
//--------------------
`timescale 1ns/1ns
`default_nettype none

module mem_system_checker (
   input logic                 clk,
   input logic                 rst,
   input cpu_if_pkg::cpu_req_t req,
   input cpu_if_pkg::cpu_rsp_t rsp,
   input logic                 busy,
   input logic                 err
);
   logic new_req;
   logic illegal;
   logic accepted;
   logic pending_q;

   // Failure count, read by the testbench at the end of the run
   int unsigned fail_cnt = 0;

   assign new_req  = req.rd | req.wr;
   assign illegal  = new_req & (busy | req.addr[0]);
   assign accepted = new_req & ~illegal;

   // Set from an accepted request until its done pulse
   always_ff @(posedge clk) begin
      if (rst) begin
         pending_q <= 1'b0;
      end else if (accepted) begin
         pending_q <= 1'b1;
      end else if (rsp.done) begin
         pending_q <= 1'b0;
      end
   end

   done_pulse_a: assert property (@(posedge clk) disable iff (rst) rsp.done |=> !rsp.done)
      else begin
         $error("done stayed high for more than one cycle");
         fail_cnt++;
      end

   done_req_a: assert property (@(posedge clk) disable iff (rst) rsp.done |-> pending_q)
      else begin
         $error("done without an accepted request");
         fail_cnt++;
      end

   reset_idle_a: assert property (@(posedge clk) rst |=> !busy)
      else begin
         $error("busy high right after reset");
         fail_cnt++;
      end

   // Err may only rise one cycle after a dropped request
   err_legal_a: assert property (@(posedge clk) disable iff (rst) $rose(err) |-> $past(illegal))
      else begin
         $error("err rose without an illegal request");
         fail_cnt++;
      end

endmodule

bind mem_system mem_system_checker i_checker (
   .clk  (clk),
   .rst  (rst),
   .req  (req),
   .rsp  (rsp),
   .busy (busy),
   .err  (err)
);

`default_nettype wire

// ==== tb_mem_system.sv ====
//--------------------
// Memory system testbench
// Directed and LFSR driven requests, checked against
// a shadow memory and tag table reference model
//--------------------
`timescale 1ns/1ns
`default_nettype none
`include "mem_sys_defs.svh"

module tb_mem_system;
   import cpu_if_pkg::*;
   import cache_pkg::*;

   localparam int DRV        = 10;
   localparam int LAT_HIT    = 2;
   localparam int LAT_CLEAN  = 9;
   localparam int LAT_DIRTY  = 13;
   localparam int N_RAND     = 200;
   localparam int N_REQ      = 220;
   localparam int MAX_CYCLES = N_REQ * 14 + 500;

   logic     clk;
   logic     rst;
   cpu_req_t req;
   cpu_rsp_t rsp;
   logic     busy;
   logic     err;

   // Reference state, processor view of memory and cache tags
   logic [`MEM_SYS_DATA_W-1:0] shadow_mem [2 ** (`MEM_SYS_ADDR_W - 1)] = '{default: '0};
   tag_t                       ref_tag [`MEM_SYS_LINES];
   logic [`MEM_SYS_LINES-1:0]  ref_valid;
   logic [`MEM_SYS_LINES-1:0]  ref_dirty;

   cpu_rsp_t    exp_q [$];
   int          lat_q [$];
   int          start_q [$];
   bit          rd_q [$];
   logic [15:0] lfsr_q;
   logic        err_exp;
   int          cycle_cnt;
   int          err_cnt;
   int          test_base;
   int          n_issued;
   int          n_done;
   int          total;

   mem_system i_dut (
      .clk  (clk),
      .rst  (rst),
      .req  (req),
      .rsp  (rsp),
      .busy (busy),
      .err  (err)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES) begin
         $display("Timeout after %0d cycles, %0d of %0d requests done",
                  cycle_cnt, n_done, n_issued);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[14:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      end
      return v;
   endfunction

   function automatic cpu_req_t mk_req(input logic rd, input logic [15:0] addr,
                                       input logic [15:0] wdata);
      cpu_req_t r;
      r.rd    = rd;
      r.wr    = ~rd;
      r.addr  = addr;
      r.wdata = wdata;
      return r;
   endfunction

   // Expected response and latency, updates the reference state
   function automatic cpu_rsp_t predict(input cpu_req_t r, output int lat);
      cache_addr_t a;
      cpu_rsp_t    e;
      logic        hit;
      a   = r.addr;
      hit = ref_valid[a.index] && (ref_tag[a.index] == a.tag);
      if (hit) begin
         lat = LAT_HIT;
      end else if (ref_valid[a.index] && ref_dirty[a.index]) begin
         lat = LAT_DIRTY;
      end else begin
         lat = LAT_CLEAN;
      end
      if (r.wr) begin
         shadow_mem[r.addr[15:1]] = r.wdata;
      end
      ref_dirty[a.index] = (hit & ref_dirty[a.index]) | r.wr;
      ref_valid[a.index] = 1'b1;
      ref_tag[a.index]   = a.tag;
      e.done  = 1'b1;
      e.hit   = hit;
      e.rdata = shadow_mem[r.addr[15:1]];
      return e;
   endfunction

   task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input bit chk_data);
      if (got.hit !== exp.hit) begin
         $display("Mismatch rsp.hit: got %h expected %h", got.hit, exp.hit);
         err_cnt++;
      end
      if (chk_data && (got.rdata !== exp.rdata)) begin
         $display("Mismatch rsp.rdata: got %h expected %h", got.rdata, exp.rdata);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_latency(input int got, input int exp);
      if (got != exp) begin
         $display("Mismatch done latency: got %h expected %h", got, exp);
         err_cnt++;
      end
   endtask

   // Compare each done pulse with the oldest expectation
   always @(negedge clk) begin
      if (!rst && rsp.done) begin
         if (exp_q.size() == 0) begin
            $display("Done pulse seen with no request outstanding");
            err_cnt++;
         end else begin
            check_rsp(rsp, exp_q.pop_front(), rd_q.pop_front());
            // Done cycle ends at the next edge
            check_latency(cycle_cnt + 1 - start_q.pop_front(), lat_q.pop_front());
            n_done++;
         end
      end
   end

   // One-cycle strobe, returns just after the sampling edge
   task automatic drive_req(input cpu_req_t r);
      @(posedge clk);
      #DRV;
      req = r;
      @(posedge clk);
      #DRV;
      req = '0;
   endtask

   task automatic send(input cpu_req_t r);
      cpu_rsp_t e;
      int       lat;
      e = predict(r, lat);
      drive_req(r);
      // Busy rises right after the sampling edge
      check_flag("busy", busy, 1'b1);
      exp_q.push_back(e);
      lat_q.push_back(lat);
      start_q.push_back(cycle_cnt);
      rd_q.push_back(r.rd);
      n_issued++;
   endtask

   task automatic wait_done();
      wait (n_done == n_issued);
      check_flag("busy", busy, 1'b0);
      check_flag("err", err, err_exp);
   endtask

   task automatic access(input cpu_req_t r);
      send(r);
      wait_done();
   endtask

   task automatic random_mix(input int n);
      logic [15:0] op;
      logic [15:0] tag;
      logic [15:0] idx;
      logic [15:0] word;
      logic [15:0] data;
      for (int i = 0; i < n; i++) begin
         op   = take_bits(1);
         tag  = take_bits(2);
         idx  = take_bits(2);
         word = take_bits(2);
         data = take_bits(16);
         access(mk_req(op[0], {3'b000, tag[1:0], 6'b0, idx[1:0], word[1:0], 1'b0}, data));
      end
   endtask

   task automatic finish_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, err_cnt - test_base);
      test_base = err_cnt;
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      req       = '0;
      lfsr_q    = 16'd62;
      err_exp   = 1'b0;
      ref_valid = '0;
      ref_dirty = '0;
      cycle_cnt = 0;
      err_cnt   = 0;
      test_base = 0;
      n_issued  = 0;
      n_done    = 0;
      repeat (4) @(posedge clk);
      #DRV;
      rst = 1'b0;
      @(negedge clk);
      check_flag("busy", busy, 1'b0);
      check_flag("err", err, 1'b0);

      access(mk_req(1'b1, 16'h1234, 16'h0000));
      access(mk_req(1'b1, 16'h1234, 16'h0000));
      finish_test(1, "read after reset");

      access(mk_req(1'b0, 16'h2464, 16'hBEEF));
      access(mk_req(1'b1, 16'h2464, 16'h0000));
      access(mk_req(1'b0, 16'h2460, 16'h1111));
      access(mk_req(1'b0, 16'h2462, 16'h2222));
      access(mk_req(1'b0, 16'h2466, 16'h3333));
      finish_test(2, "write then read");

      // Same index, tag 9 evicts the dirty line
      access(mk_req(1'b1, 16'h4C64, 16'h0000));
      access(mk_req(1'b1, 16'h2464, 16'h0000));
      access(mk_req(1'b1, 16'h2460, 16'h0000));
      finish_test(3, "dirty eviction");

      random_mix(N_RAND);
      finish_test(4, "random mix");

      // Err is expected to rise from here on
      $assertoff(0, i_dut.i_checker.err_legal_a);
      drive_req(mk_req(1'b1, 16'h0101, 16'h0000));
      repeat (LAT_DIRTY + 1) @(negedge clk);
      err_exp = 1'b1;
      check_flag("err", err, 1'b1);
      send(mk_req(1'b1, 16'h7FF0, 16'h0000));
      repeat (2) @(posedge clk);
      drive_req(mk_req(1'b0, 16'h7FF2, 16'hA5A5));
      wait_done();
      access(mk_req(1'b1, 16'h7FF2, 16'h0000));
      finish_test(5, "dropped requests");

      total = err_cnt + int'(i_dut.i_checker.fail_cnt);
      $display("Run complete: %0d requests, %0d errors", n_issued, total);
      if (total == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
